//--- verilog/axil_pkg.sv
package axil_pkg;

    // Byte address on the host port.
    typedef logic [15:0] addr_t;

    // One register word.
    typedef logic [31:0] data_t;

    // Write byte enables, one per data byte.
    typedef logic [3:0] strb_t;

    // AXI response code.
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- verilog/fall_through_register.sv
`timescale 1ns/1ps

module fall_through_register #(
    parameter int unsigned WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             rst_i,

    input  logic             valid_i,
    output logic             ready_o,
    input  logic [WIDTH-1:0] data_i,

    output logic             valid_o,
    input  logic             ready_i,
    output logic [WIDTH-1:0] data_o
);

    logic             full_q;
    logic [WIDTH-1:0] data_q;
    logic             capture;

    // Store only when the item cannot pass straight through.
    assign capture = valid_i && !full_q && !ready_i;

    assign ready_o = !full_q;
    assign valid_o = full_q || valid_i;
    assign data_o  = full_q ? data_q : data_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full_q <= 1'b0;
        end else if (capture) begin
            full_q <= 1'b1;
        end else if (full_q && ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            data_q <= data_i;
        end
    end

endmodule

//--- verilog/axil_fall_through.sv
`timescale 1ns/1ps

module axil_fall_through #(
    parameter bit BYPASS_AW = 1'b0,
    parameter bit BYPASS_W  = 1'b0,
    parameter bit BYPASS_B  = 1'b0,
    parameter bit BYPASS_AR = 1'b0,
    parameter bit BYPASS_R  = 1'b0
) (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            aw_valid_i,
    output logic            aw_ready_o,
    input  axil_pkg::addr_t aw_addr_i,

    input  logic            w_valid_i,
    output logic            w_ready_o,
    input  axil_pkg::data_t w_data_i,
    input  axil_pkg::strb_t w_strb_i,

    output logic            b_valid_o,
    input  logic            b_ready_i,
    output axil_pkg::resp_t b_resp_o,

    input  logic            ar_valid_i,
    output logic            ar_ready_o,
    input  axil_pkg::addr_t ar_addr_i,

    output logic            r_valid_o,
    input  logic            r_ready_i,
    output axil_pkg::data_t r_data_o,
    output axil_pkg::resp_t r_resp_o,

    output logic            m_aw_valid_o,
    input  logic            m_aw_ready_i,
    output axil_pkg::addr_t m_aw_addr_o,

    output logic            m_w_valid_o,
    input  logic            m_w_ready_i,
    output axil_pkg::data_t m_w_data_o,
    output axil_pkg::strb_t m_w_strb_o,

    input  logic            m_b_valid_i,
    output logic            m_b_ready_o,
    input  axil_pkg::resp_t m_b_resp_i,

    output logic            m_ar_valid_o,
    input  logic            m_ar_ready_i,
    output axil_pkg::addr_t m_ar_addr_o,

    input  logic            m_r_valid_i,
    output logic            m_r_ready_o,
    input  axil_pkg::data_t m_r_data_i,
    input  axil_pkg::resp_t m_r_resp_i
);

    localparam int unsigned AW_W = $bits(axil_pkg::addr_t);
    localparam int unsigned W_W  = $bits(axil_pkg::data_t) + $bits(axil_pkg::strb_t);
    localparam int unsigned B_W  = $bits(axil_pkg::resp_t);
    localparam int unsigned AR_W = $bits(axil_pkg::addr_t);
    localparam int unsigned R_W  = $bits(axil_pkg::data_t) + $bits(axil_pkg::resp_t);

    // Channel payloads packed into one word each.
    logic [AW_W-1:0] aw_in, aw_out;
    logic [W_W-1:0]  w_in,  w_out;
    logic [B_W-1:0]  b_in,  b_out;
    logic [AR_W-1:0] ar_in, ar_out;
    logic [R_W-1:0]  r_in,  r_out;

    assign aw_in = aw_addr_i;
    assign w_in  = {w_data_i, w_strb_i};
    assign b_in  = m_b_resp_i;
    assign ar_in = ar_addr_i;
    assign r_in  = {m_r_data_i, m_r_resp_i};

    assign m_aw_addr_o             = aw_out;
    assign {m_w_data_o, m_w_strb_o} = w_out;
    assign b_resp_o                = b_out;
    assign m_ar_addr_o             = ar_out;
    assign {r_data_o, r_resp_o}    = r_out;

    generate
        if (BYPASS_AW) begin : g_aw_wire
            assign m_aw_valid_o = aw_valid_i;
            assign aw_ready_o   = m_aw_ready_i;
            assign aw_out       = aw_in;
        end else begin : g_aw_buf
            fall_through_register #(.WIDTH(AW_W)) u_aw (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .valid_i (aw_valid_i),
                .ready_o (aw_ready_o),
                .data_i  (aw_in),
                .valid_o (m_aw_valid_o),
                .ready_i (m_aw_ready_i),
                .data_o  (aw_out)
            );
        end

        if (BYPASS_W) begin : g_w_wire
            assign m_w_valid_o = w_valid_i;
            assign w_ready_o   = m_w_ready_i;
            assign w_out       = w_in;
        end else begin : g_w_buf
            fall_through_register #(.WIDTH(W_W)) u_w (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .valid_i (w_valid_i),
                .ready_o (w_ready_o),
                .data_i  (w_in),
                .valid_o (m_w_valid_o),
                .ready_i (m_w_ready_i),
                .data_o  (w_out)
            );
        end

        // Responses flow from the bank back to the host.
        if (BYPASS_B) begin : g_b_wire
            assign b_valid_o   = m_b_valid_i;
            assign m_b_ready_o = b_ready_i;
            assign b_out       = b_in;
        end else begin : g_b_buf
            fall_through_register #(.WIDTH(B_W)) u_b (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .valid_i (m_b_valid_i),
                .ready_o (m_b_ready_o),
                .data_i  (b_in),
                .valid_o (b_valid_o),
                .ready_i (b_ready_i),
                .data_o  (b_out)
            );
        end

        if (BYPASS_AR) begin : g_ar_wire
            assign m_ar_valid_o = ar_valid_i;
            assign ar_ready_o   = m_ar_ready_i;
            assign ar_out       = ar_in;
        end else begin : g_ar_buf
            fall_through_register #(.WIDTH(AR_W)) u_ar (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .valid_i (ar_valid_i),
                .ready_o (ar_ready_o),
                .data_i  (ar_in),
                .valid_o (m_ar_valid_o),
                .ready_i (m_ar_ready_i),
                .data_o  (ar_out)
            );
        end

        if (BYPASS_R) begin : g_r_wire
            assign r_valid_o   = m_r_valid_i;
            assign m_r_ready_o = r_ready_i;
            assign r_out       = r_in;
        end else begin : g_r_buf
            fall_through_register #(.WIDTH(R_W)) u_r (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .valid_i (m_r_valid_i),
                .ready_o (m_r_ready_o),
                .data_i  (r_in),
                .valid_o (r_valid_o),
                .ready_i (r_ready_i),
                .data_o  (r_out)
            );
        end
    endgenerate

endmodule

//--- verilog/axil_reg_bank.sv
`timescale 1ns/1ps

module axil_reg_bank #(
    parameter int unsigned NUM_REGS = 16
) (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            aw_valid_i,
    output logic            aw_ready_o,
    input  axil_pkg::addr_t aw_addr_i,

    input  logic            w_valid_i,
    output logic            w_ready_o,
    input  axil_pkg::data_t w_data_i,
    input  axil_pkg::strb_t w_strb_i,

    output logic            b_valid_o,
    input  logic            b_ready_i,
    output axil_pkg::resp_t b_resp_o,

    input  logic            ar_valid_i,
    output logic            ar_ready_o,
    input  axil_pkg::addr_t ar_addr_i,

    output logic            r_valid_o,
    input  logic            r_ready_i,
    output axil_pkg::data_t r_data_o,
    output axil_pkg::resp_t r_resp_o
);

    localparam int unsigned IDX_W  = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
    localparam int unsigned WORD_W = $bits(axil_pkg::addr_t) - 2;
    localparam int unsigned NBYTES = $bits(axil_pkg::strb_t);

    axil_pkg::data_t regs_q [NUM_REGS];

    logic [WORD_W-1:0] wr_word;
    logic [WORD_W-1:0] rd_word;
    logic              wr_in_range;
    logic              rd_in_range;
    logic              wr_fire;
    logic              rd_fire;

    logic              b_pending_q;
    axil_pkg::resp_t   b_resp_q;
    logic              r_pending_q;
    axil_pkg::data_t   r_data_q;
    axil_pkg::resp_t   r_resp_q;
    axil_pkg::data_t   rd_word_data;

    // Word index is the byte address over four.
    assign wr_word     = aw_addr_i[$bits(axil_pkg::addr_t)-1:2];
    assign rd_word     = ar_addr_i[$bits(axil_pkg::addr_t)-1:2];
    assign wr_in_range = wr_word < NUM_REGS;
    assign rd_in_range = rd_word < NUM_REGS;

    // AW and W are taken together, and only with the B slot free.
    assign wr_fire    = aw_valid_i && w_valid_i && !b_pending_q;
    assign aw_ready_o = wr_fire;
    assign w_ready_o  = wr_fire;

    assign ar_ready_o = !r_pending_q;
    assign rd_fire    = ar_valid_i && !r_pending_q;

    assign b_valid_o = b_pending_q;
    assign b_resp_o  = b_resp_q;
    assign r_valid_o = r_pending_q;
    assign r_data_o  = r_data_q;
    assign r_resp_o  = r_resp_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_fire && wr_in_range) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (w_strb_i[b]) begin
                    regs_q[wr_word[IDX_W-1:0]][8*b +: 8] <= w_data_i[8*b +: 8];
                end
            end
        end
    end

    // Write response.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            b_pending_q <= 1'b0;
        end else if (wr_fire) begin
            b_pending_q <= 1'b1;
        end else if (b_ready_i) begin
            b_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            b_resp_q <= wr_in_range ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

    // Out of range reads as zero.
    always_comb begin
        rd_word_data = '0;
        if (rd_in_range) begin
            rd_word_data = regs_q[rd_word[IDX_W-1:0]];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            r_pending_q <= 1'b0;
        end else if (rd_fire) begin
            r_pending_q <= 1'b1;
        end else if (r_ready_i) begin
            r_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            r_data_q <= rd_word_data;
            r_resp_q <= rd_in_range ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

endmodule

//--- verilog/axil_buffered_regs.sv
`timescale 1ns/1ps

module axil_buffered_regs #(
    parameter int unsigned NUM_REGS  = 16,
    parameter bit          BYPASS_AW = 1'b0,
    parameter bit          BYPASS_W  = 1'b0,
    parameter bit          BYPASS_B  = 1'b0,
    parameter bit          BYPASS_AR = 1'b0,
    parameter bit          BYPASS_R  = 1'b0
) (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            aw_valid_i,
    output logic            aw_ready_o,
    input  axil_pkg::addr_t aw_addr_i,

    input  logic            w_valid_i,
    output logic            w_ready_o,
    input  axil_pkg::data_t w_data_i,
    input  axil_pkg::strb_t w_strb_i,

    output logic            b_valid_o,
    input  logic            b_ready_i,
    output axil_pkg::resp_t b_resp_o,

    input  logic            ar_valid_i,
    output logic            ar_ready_o,
    input  axil_pkg::addr_t ar_addr_i,

    output logic            r_valid_o,
    input  logic            r_ready_i,
    output axil_pkg::data_t r_data_o,
    output axil_pkg::resp_t r_resp_o
);

    // Cut to bank.
    logic            bank_aw_valid, bank_aw_ready;
    axil_pkg::addr_t bank_aw_addr;
    logic            bank_w_valid, bank_w_ready;
    axil_pkg::data_t bank_w_data;
    axil_pkg::strb_t bank_w_strb;
    logic            bank_b_valid, bank_b_ready;
    axil_pkg::resp_t bank_b_resp;
    logic            bank_ar_valid, bank_ar_ready;
    axil_pkg::addr_t bank_ar_addr;
    logic            bank_r_valid, bank_r_ready;
    axil_pkg::data_t bank_r_data;
    axil_pkg::resp_t bank_r_resp;

    axil_fall_through #(
        .BYPASS_AW (BYPASS_AW),
        .BYPASS_W  (BYPASS_W),
        .BYPASS_B  (BYPASS_B),
        .BYPASS_AR (BYPASS_AR),
        .BYPASS_R  (BYPASS_R)
    ) u_cut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .aw_valid_i   (aw_valid_i),
        .aw_ready_o   (aw_ready_o),
        .aw_addr_i    (aw_addr_i),
        .w_valid_i    (w_valid_i),
        .w_ready_o    (w_ready_o),
        .w_data_i     (w_data_i),
        .w_strb_i     (w_strb_i),
        .b_valid_o    (b_valid_o),
        .b_ready_i    (b_ready_i),
        .b_resp_o     (b_resp_o),
        .ar_valid_i   (ar_valid_i),
        .ar_ready_o   (ar_ready_o),
        .ar_addr_i    (ar_addr_i),
        .r_valid_o    (r_valid_o),
        .r_ready_i    (r_ready_i),
        .r_data_o     (r_data_o),
        .r_resp_o     (r_resp_o),
        .m_aw_valid_o (bank_aw_valid),
        .m_aw_ready_i (bank_aw_ready),
        .m_aw_addr_o  (bank_aw_addr),
        .m_w_valid_o  (bank_w_valid),
        .m_w_ready_i  (bank_w_ready),
        .m_w_data_o   (bank_w_data),
        .m_w_strb_o   (bank_w_strb),
        .m_b_valid_i  (bank_b_valid),
        .m_b_ready_o  (bank_b_ready),
        .m_b_resp_i   (bank_b_resp),
        .m_ar_valid_o (bank_ar_valid),
        .m_ar_ready_i (bank_ar_ready),
        .m_ar_addr_o  (bank_ar_addr),
        .m_r_valid_i  (bank_r_valid),
        .m_r_ready_o  (bank_r_ready),
        .m_r_data_i   (bank_r_data),
        .m_r_resp_i   (bank_r_resp)
    );

    axil_reg_bank #(
        .NUM_REGS (NUM_REGS)
    ) u_bank (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .aw_valid_i (bank_aw_valid),
        .aw_ready_o (bank_aw_ready),
        .aw_addr_i  (bank_aw_addr),
        .w_valid_i  (bank_w_valid),
        .w_ready_o  (bank_w_ready),
        .w_data_i   (bank_w_data),
        .w_strb_i   (bank_w_strb),
        .b_valid_o  (bank_b_valid),
        .b_ready_i  (bank_b_ready),
        .b_resp_o   (bank_b_resp),
        .ar_valid_i (bank_ar_valid),
        .ar_ready_o (bank_ar_ready),
        .ar_addr_i  (bank_ar_addr),
        .r_valid_o  (bank_r_valid),
        .r_ready_i  (bank_r_ready),
        .r_data_o   (bank_r_data),
        .r_resp_o   (bank_r_resp)
    );

endmodule

//--- test/axil_check.sv
`timescale 1ns/1ps

module axil_check #(
    parameter int unsigned NUM_REGS = 16
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            aw_valid_i,
    input  logic            aw_ready_i,
    input  axil_pkg::addr_t aw_addr_i,
    input  logic            w_valid_i,
    input  logic            w_ready_i,
    input  axil_pkg::data_t w_data_i,
    input  axil_pkg::strb_t w_strb_i,
    input  logic            b_valid_i,
    input  logic            b_ready_i,
    input  axil_pkg::resp_t b_resp_i,
    input  logic            ar_valid_i,
    input  logic            ar_ready_i,
    input  axil_pkg::addr_t ar_addr_i,
    input  logic            r_valid_i,
    input  logic            r_ready_i,
    input  axil_pkg::data_t r_data_i,
    input  axil_pkg::resp_t r_resp_i,
    output int              errors_o,
    output int              checks_o,
    output int              open_o
);

    axil_pkg::data_t shadow [NUM_REGS];
    axil_pkg::addr_t aw_q [$];
    axil_pkg::data_t wd_q [$];
    axil_pkg::strb_t ws_q [$];
    axil_pkg::addr_t ar_q [$];

    logic            b_held;
    axil_pkg::resp_t b_resp_prev;
    logic            r_held;
    axil_pkg::data_t r_data_prev;
    axil_pkg::resp_t r_resp_prev;

    initial begin
        errors_o = 0;
        checks_o = 0;
        open_o   = 0;
        b_held   = 1'b0;
        r_held   = 1'b0;
    end

    // Expected {resp, word}; a write returns the merged word.
    function automatic logic [33:0] expect_access(input axil_pkg::addr_t addr,
                                                  input logic is_write,
                                                  input axil_pkg::data_t wdata,
                                                  input axil_pkg::strb_t strb);
        int unsigned     word;
        axil_pkg::data_t value;
        word = addr >> 2;
        if (word >= NUM_REGS) begin
            return {axil_pkg::RESP_SLVERR, 32'h0};
        end
        value = shadow[word];
        if (is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    value[8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        return {axil_pkg::RESP_OKAY, value};
    endfunction

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors_o++;
    endtask

    always @(posedge clk_i) begin
        logic [33:0]     expected;
        axil_pkg::addr_t addr;
        axil_pkg::data_t wdata;
        axil_pkg::strb_t strb;
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                shadow[i] = '0;
            end
            aw_q.delete();
            wd_q.delete();
            ws_q.delete();
            ar_q.delete();
            b_held = 1'b0;
            r_held = 1'b0;
        end else begin
            if (b_held && (!b_valid_i || b_resp_i !== b_resp_prev)) begin
                report_fail("B response changed before its handshake");
            end
            if (r_held && (!r_valid_i || r_data_i !== r_data_prev || r_resp_i !== r_resp_prev)) begin
                report_fail("R response changed before its handshake");
            end
            // A response never belongs to a request taken on the same edge.
            if (b_valid_i && (aw_q.size() == 0 || wd_q.size() == 0)) begin
                report_fail("B valid without an open write request");
            end else if (b_valid_i && b_ready_i) begin
                addr     = aw_q.pop_front();
                wdata    = wd_q.pop_front();
                strb     = ws_q.pop_front();
                expected = expect_access(addr, 1'b1, wdata, strb);
                checks_o++;
                if (b_resp_i !== expected[33:32]) begin
                    report_fail($sformatf("write 0x%04h resp %0d, expected %0d",
                                          addr, b_resp_i, expected[33:32]));
                end
                if (expected[33:32] == axil_pkg::RESP_OKAY) begin
                    shadow[addr[15:2]] = expected[31:0];
                end
            end
            if (r_valid_i && ar_q.size() == 0) begin
                report_fail("R valid without an open read request");
            end else if (r_valid_i && r_ready_i) begin
                addr     = ar_q.pop_front();
                expected = expect_access(addr, 1'b0, '0, '0);
                checks_o++;
                if (r_resp_i !== expected[33:32] || r_data_i !== expected[31:0]) begin
                    report_fail($sformatf("read 0x%04h got %08h resp %0d, want %08h resp %0d",
                                          addr, r_data_i, r_resp_i,
                                          expected[31:0], expected[33:32]));
                end
            end
            if (aw_valid_i && aw_ready_i) aw_q.push_back(aw_addr_i);
            if (w_valid_i && w_ready_i) begin
                wd_q.push_back(w_data_i);
                ws_q.push_back(w_strb_i);
            end
            if (ar_valid_i && ar_ready_i) ar_q.push_back(ar_addr_i);
            b_held      = b_valid_i && !b_ready_i;
            b_resp_prev = b_resp_i;
            r_held      = r_valid_i && !r_ready_i;
            r_data_prev = r_data_i;
            r_resp_prev = r_resp_i;
        end
        open_o = aw_q.size() + wd_q.size() + ar_q.size();
    end

endmodule

//--- test/tb_axil_buffered_regs.sv
`timescale 1ns/1ps

module tb_axil_buffered_regs;

    localparam int unsigned NUM_REGS = 16;
    localparam int          TIMEOUT  = 200;

    logic            clk;
    logic            rst;
    logic            aw_valid, aw_ready;
    axil_pkg::addr_t aw_addr;
    logic            w_valid, w_ready;
    axil_pkg::data_t w_data;
    axil_pkg::strb_t w_strb;
    logic            b_valid, b_ready;
    axil_pkg::resp_t b_resp;
    logic            ar_valid, ar_ready;
    axil_pkg::addr_t ar_addr;
    logic            r_valid, r_ready;
    axil_pkg::data_t r_data;
    axil_pkg::resp_t r_resp;

    logic [31:0] seed;
    logic        stall_en;
    int          timeouts;
    int          mismatches;
    int          checked;
    int          open_cnt;

    always #4 clk = ~clk;

    axil_buffered_regs #(
        .NUM_REGS (NUM_REGS),
        .BYPASS_AW(1'b0),
        .BYPASS_W (1'b1),
        .BYPASS_B (1'b0),
        .BYPASS_AR(1'b0),
        .BYPASS_R (1'b0)
    ) i_dut (
        .clk_i      (clk),
        .rst_i      (rst),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .aw_addr_i  (aw_addr),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .w_data_i   (w_data),
        .w_strb_i   (w_strb),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready),
        .b_resp_o   (b_resp),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_addr_i  (ar_addr),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp)
    );

    axil_check #(.NUM_REGS(NUM_REGS)) u_check (
        .clk_i(clk), .rst_i(rst),
        .aw_valid_i(aw_valid), .aw_ready_i(aw_ready), .aw_addr_i(aw_addr),
        .w_valid_i(w_valid), .w_ready_i(w_ready), .w_data_i(w_data), .w_strb_i(w_strb),
        .b_valid_i(b_valid), .b_ready_i(b_ready), .b_resp_i(b_resp),
        .ar_valid_i(ar_valid), .ar_ready_i(ar_ready), .ar_addr_i(ar_addr),
        .r_valid_i(r_valid), .r_ready_i(r_ready), .r_data_i(r_data), .r_resp_i(r_resp),
        .errors_o(mismatches), .checks_o(checked), .open_o(open_cnt)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = lcg_step(seed);
        r    = seed;
    endtask

    // Word index 16 or more when outside is set.
    function automatic axil_pkg::addr_t pick_addr(input logic [31:0] r, input logic outside);
        axil_pkg::addr_t a;
        a = {10'b0, r[27:24], 2'b00};
        if (outside) begin
            a[15:6] = r[17:8] | 10'h001;
        end
        return a;
    endfunction

    task automatic pick_ready(output logic rdy);
        logic [31:0] r;
        next_rand(r);
        rdy = !stall_en || (r[31:30] != 2'b00);
    endtask

    // Called on a falling edge, returns on a falling edge.
    task automatic write_txn(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                             input axil_pkg::strb_t strb, input int aw_start, input int w_start);
        logic aw_done;
        logic w_done;
        logic got;
        int   cnt;
        aw_done = 1'b0;
        w_done  = 1'b0;
        got     = 1'b0;
        cnt     = 0;
        aw_addr = addr;
        w_data  = data;
        w_strb  = strb;
        while (!(aw_done && w_done) && cnt < TIMEOUT) begin
            aw_valid = !aw_done && (cnt >= aw_start);
            w_valid  = !w_done && (cnt >= w_start);
            @(posedge clk);
            if (aw_valid && aw_ready) aw_done = 1'b1;
            if (w_valid && w_ready) w_done = 1'b1;
            cnt++;
            @(negedge clk);
        end
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        if (!(aw_done && w_done)) begin
            $display("Timeout: write to 0x%04h was not accepted", addr);
            timeouts++;
        end
        cnt = 0;
        while (!got && cnt < TIMEOUT) begin
            pick_ready(b_ready);
            @(posedge clk);
            if (b_valid && b_ready) got = 1'b1;
            cnt++;
            @(negedge clk);
        end
        b_ready = 1'b0;
        if (!got) begin
            $display("Timeout: no write response for 0x%04h", addr);
            timeouts++;
        end
    endtask

    task automatic read_txn(input axil_pkg::addr_t addr);
        logic done;
        logic got;
        int   cnt;
        done    = 1'b0;
        got     = 1'b0;
        cnt     = 0;
        ar_addr = addr;
        while (!done && cnt < TIMEOUT) begin
            ar_valid = 1'b1;
            @(posedge clk);
            if (ar_ready) done = 1'b1;
            cnt++;
            @(negedge clk);
        end
        ar_valid = 1'b0;
        if (!done) begin
            $display("Timeout: read of 0x%04h was not accepted", addr);
            timeouts++;
        end
        cnt = 0;
        while (!got && cnt < TIMEOUT) begin
            pick_ready(r_ready);
            @(posedge clk);
            if (r_valid && r_ready) got = 1'b1;
            cnt++;
            @(negedge clk);
        end
        r_ready = 1'b0;
        if (!got) begin
            $display("Timeout: no read data for 0x%04h", addr);
            timeouts++;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        int          aw_s;
        int          w_s;
        clk      = 1'b0;
        rst      = 1'b1;
        aw_valid = 1'b0;
        aw_addr  = '0;
        w_valid  = 1'b0;
        w_data   = '0;
        w_strb   = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar_addr  = '0;
        r_ready  = 1'b0;
        seed     = 32'h6f9e;
        stall_en = 1'b0;
        timeouts = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset contents.
        for (int i = 0; i < NUM_REGS; i++) read_txn(axil_pkg::addr_t'(i * 4));
        for (int i = 0; i < NUM_REGS; i++) begin
            next_rand(d);
            write_txn(axil_pkg::addr_t'(i * 4), d, 4'hf, 0, 0);
        end
        for (int i = 0; i < NUM_REGS; i++) read_txn(axil_pkg::addr_t'(i * 4));

        // Byte strobes on random words.
        repeat (24) begin
            next_rand(r);
            next_rand(d);
            write_txn(pick_addr(r, 1'b0), d, r[3:0], 0, 0);
            read_txn(pick_addr(r, 1'b0));
        end

        // Outside the bank.
        write_txn(16'h0040, 32'hdead_beef, 4'hf, 0, 0);
        write_txn(16'hfffc, 32'h1234_5678, 4'hf, 0, 0);
        read_txn(16'h0040);
        read_txn(16'hfffc);
        repeat (8) begin
            next_rand(r);
            next_rand(d);
            write_txn(pick_addr(r, 1'b1), d, 4'hf, 0, 0);
            read_txn(pick_addr(r, 1'b1));
            read_txn(pick_addr(r, 1'b0));
        end

        // Mixed traffic with response stalls and skewed AW/W.
        stall_en = 1'b1;
        repeat (200) begin
            next_rand(r);
            next_rand(d);
            aw_s = 0;
            w_s  = 0;
            case (r[31:30])
                2'd1:    w_s  = int'(r[29:28]) + 1;
                2'd2:    aw_s = int'(r[29:27]) + 1;
                default: aw_s = 0;
            endcase
            if (r[0]) begin
                write_txn(pick_addr(r, r[6:4] == 3'd0), d, r[23:20], aw_s, w_s);
            end else begin
                read_txn(pick_addr(r, r[6:4] == 3'd0));
            end
        end
        stall_en = 1'b0;

        repeat (2) @(negedge clk);
        if (open_cnt != 0) begin
            $display("Requests left without a response: %0d", open_cnt);
            timeouts++;
        end
        $display("Errors: %0d mismatches, %0d timeouts or lost responses, %0d responses checked",
                 mismatches, timeouts, checked);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- axil_buffered_regs.f
verilog/axil_pkg.sv
verilog/fall_through_register.sv
verilog/axil_fall_through.sv
verilog/axil_reg_bank.sv
verilog/axil_buffered_regs.sv
test/axil_check.sv
test/tb_axil_buffered_regs.sv

//--- Bender.yml
package:
  name: axil_buffered_regs

sources:
  - verilog/axil_pkg.sv
  - verilog/fall_through_register.sv
  - verilog/axil_fall_through.sv
  - verilog/axil_reg_bank.sv
  - verilog/axil_buffered_regs.sv
  - target: test
    files:
      - test/axil_check.sv
      - test/tb_axil_buffered_regs.sv
